//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
src/bus_pkg.sv
src/soc_map_pkg.sv
src/req_buffer.sv
src/addr_router.sv
src/boot_rom.sv
src/sram_bank.sv
src/console_regs.sv
src/soc_top.sv
verification/clk_gen.sv
verification/tb_soc.sv

//--- src/addr_router.sv
// Decodes the head request against the memory map and dispatches it to one target
// Takes a request only while a response credit is held, answers one cycle later
`timescale 1ns/10ps

module addr_router (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic                                    head_valid_i,
  input  logic                                    head_write_i,
  input  logic [soc_map_pkg::AddrWidth-1:0]       head_addr_i,
  input  logic [bus_pkg::DataWidth-1:0]           head_wdata_i,
  input  logic [bus_pkg::StrbWidth-1:0]           head_strb_i,
  input  logic                                    rsp_credit_i,
  input  logic [bus_pkg::DataWidth-1:0]           rom_rdata_i,
  input  logic [bus_pkg::DataWidth-1:0]           sram_rdata_i,
  input  logic [bus_pkg::DataWidth-1:0]           console_rdata_i,
  output logic                                    pop_o,
  output logic                                    rom_sel_o,
  output logic                                    sram_sel_o,
  output logic                                    console_sel_o,
  output logic                                    mem_write_o,
  output logic [soc_map_pkg::IndexWidth-1:0]      mem_index_o,
  output logic [bus_pkg::DataWidth-1:0]           mem_wdata_o,
  output logic [bus_pkg::StrbWidth-1:0]           mem_strb_o,
  output logic [soc_map_pkg::ConsoleOffWidth-1:0] console_off_o,
  output logic                                    rsp_valid_o,
  output logic [bus_pkg::DataWidth-1:0]           rsp_rdata_o,
  output logic                                    rsp_err_o
);

  soc_map_pkg::addr_word_u            head_addr;
  soc_map_pkg::target_e               target;
  soc_map_pkg::target_e               target_q;
  logic                               take;
  logic                               write_q;
  logic                               rsp_valid_q;
  logic [bus_pkg::CreditCntWidth-1:0] credit_q;

  assign head_addr.flat = head_addr_i;

  // Region decode, end addresses are exclusive
  always_comb begin
    target = soc_map_pkg::NONE;
    if (head_addr.flat >= soc_map_pkg::RomBase &&
        head_addr.flat < soc_map_pkg::RomBase + soc_map_pkg::RomLength) begin
      target = soc_map_pkg::ROM;
    end else if (head_addr.flat >= soc_map_pkg::UartBase &&
                 head_addr.flat < soc_map_pkg::UartBase + soc_map_pkg::UartLength) begin
      target = soc_map_pkg::UART;
    end else if (head_addr.flat >= soc_map_pkg::DramBase &&
                 head_addr.flat < soc_map_pkg::DramBase + soc_map_pkg::DramLength) begin
      target = soc_map_pkg::DRAM;
    end
  end

  assign take  = head_valid_i && (credit_q != '0);
  assign pop_o = take;

  assign rom_sel_o     = take && (target == soc_map_pkg::ROM);
  assign sram_sel_o    = take && (target == soc_map_pkg::DRAM);
  assign console_sel_o = take && (target == soc_map_pkg::UART);
  assign mem_write_o   = head_write_i;
  assign mem_index_o   = head_addr.fields.index;
  assign mem_wdata_o   = head_wdata_i;
  assign mem_strb_o    = head_strb_i;
  assign console_off_o = {head_addr.fields.index, head_addr.fields.offset};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
      credit_q    <= bus_pkg::RspCreditInit;
    end else begin
      rsp_valid_q <= take;
      case ({rsp_credit_i, take})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Which target answers next cycle
  always_ff @(posedge clk_i) begin
    if (take) begin
      target_q <= target;
      write_q  <= head_write_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_valid_q && (target_q == soc_map_pkg::NONE);

  always_comb begin
    rsp_rdata_o = '0;
    if (!write_q) begin
      case (target_q)
        soc_map_pkg::ROM:  rsp_rdata_o = rom_rdata_i;
        soc_map_pkg::UART: rsp_rdata_o = console_rdata_i;
        soc_map_pkg::DRAM: rsp_rdata_o = sram_rdata_i;
        default:           rsp_rdata_o = '0;
      endcase
    end
  end

endmodule

//--- src/boot_rom.sv
// Boot ROM holding the fixed boot image
// Registered read one cycle after a select, writes never reach the array
`timescale 1ns/10ps

module boot_rom (
  input  logic                               clk_i,
  input  logic                               sel_i,
  input  logic [soc_map_pkg::IndexWidth-1:0] index_i,
  output logic [bus_pkg::DataWidth-1:0]      rdata_o
);

  logic [soc_map_pkg::BootIdxWidth-1:0] rom_idx;

  // Image wraps every BootWords words
  assign rom_idx = index_i[soc_map_pkg::BootIdxWidth-1:0];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= soc_map_pkg::BootImage[rom_idx];
    end
  end

endmodule

//--- src/bus_pkg.sv
// Bus widths and credit counts of the requester port
// Shared by every module that sits on the request or response path
package bus_pkg;

  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Credits held by the requester and by the router after reset
  localparam int unsigned ReqCredits = 2;
  localparam int unsigned RspCredits = 2;

  localparam int unsigned MaxCredits =
    (ReqCredits > RspCredits) ? ReqCredits : RspCredits;
  localparam int unsigned CreditCntWidth = $clog2(MaxCredits + 1);

  localparam logic [CreditCntWidth-1:0] RspCreditInit = CreditCntWidth'(RspCredits);

  // Request FIFO pointers, one entry per request credit
  localparam int unsigned ReqPtrWidth = (ReqCredits > 1) ? $clog2(ReqCredits) : 1;
  localparam logic [ReqPtrWidth-1:0] ReqLastPtr = ReqPtrWidth'(ReqCredits - 1);

endpackage

//--- src/console_regs.sv
// Mock console in the UART region with a transmit register and an exit code
// Writes to the transmit offset emit one byte, the exit code is readable back
`timescale 1ns/10ps

module console_regs (
  input  logic                                    clk_i,
  input  logic                                    arst_n_i,
  input  logic                                    sel_i,
  input  logic                                    write_i,
  input  logic [soc_map_pkg::ConsoleOffWidth-1:0] off_i,
  input  logic [bus_pkg::DataWidth-1:0]           wdata_i,
  output logic [bus_pkg::DataWidth-1:0]           rdata_o,
  output logic                                    tx_valid_o,
  output logic [7:0]                              tx_data_o,
  output logic [soc_map_pkg::ExitWidth-1:0]       exit_o
);

  logic wr_tx;
  logic wr_exit;

  assign wr_tx   = sel_i && write_i && (off_i == soc_map_pkg::ConsoleTxOff);
  assign wr_exit = sel_i && write_i && (off_i == soc_map_pkg::ConsoleExitOff);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_valid_o <= 1'b0;
      exit_o     <= '0;
    end else begin
      tx_valid_o <= wr_tx;
      if (wr_exit) begin
        exit_o <= wdata_i[soc_map_pkg::ExitWidth-1:0];
      end
    end
  end

  // Low byte goes out with the tx pulse
  always_ff @(posedge clk_i) begin
    if (wr_tx) begin
      tx_data_o <= wdata_i[7:0];
    end
  end

  // Only the exit register reads back, everything else is zero
  always_ff @(posedge clk_i) begin
    if (sel_i && !write_i) begin
      if (off_i == soc_map_pkg::ConsoleExitOff) begin
        rdata_o <= bus_pkg::DataWidth'(exit_o);
      end else begin
        rdata_o <= '0;
      end
    end
  end

endmodule

//--- src/req_buffer.sv
// Request FIFO sized to the request credits, so it can never overflow
// Each pop of the head gives one credit back to the requester
`timescale 1ns/10ps

module req_buffer (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                req_valid_i,
  input  logic                                req_write_i,
  input  logic [soc_map_pkg::AddrWidth-1:0]   req_addr_i,
  input  logic [bus_pkg::DataWidth-1:0]       req_wdata_i,
  input  logic [bus_pkg::StrbWidth-1:0]       req_strb_i,
  input  logic                                pop_i,
  output logic                                head_valid_o,
  output logic                                head_write_o,
  output logic [soc_map_pkg::AddrWidth-1:0]   head_addr_o,
  output logic [bus_pkg::DataWidth-1:0]       head_wdata_o,
  output logic [bus_pkg::StrbWidth-1:0]       head_strb_o,
  output logic                                req_credit_o
);

  logic                              write_mem [bus_pkg::ReqCredits];
  logic [soc_map_pkg::AddrWidth-1:0] addr_mem  [bus_pkg::ReqCredits];
  logic [bus_pkg::DataWidth-1:0]     wdata_mem [bus_pkg::ReqCredits];
  logic [bus_pkg::StrbWidth-1:0]     strb_mem  [bus_pkg::ReqCredits];

  logic [bus_pkg::ReqPtrWidth-1:0]    wr_ptr_q;
  logic [bus_pkg::ReqPtrWidth-1:0]    rd_ptr_q;
  logic [bus_pkg::CreditCntWidth-1:0] count_q;
  logic                               do_pop;

  function automatic logic [bus_pkg::ReqPtrWidth-1:0] next_ptr(
    input logic [bus_pkg::ReqPtrWidth-1:0] ptr
  );
    if (ptr == bus_pkg::ReqLastPtr) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_valid_o = (count_q != '0);
  assign do_pop       = pop_i && head_valid_o;
  assign req_credit_o = do_pop;

  assign head_write_o = write_mem[rd_ptr_q];
  assign head_addr_o  = addr_mem[rd_ptr_q];
  assign head_wdata_o = wdata_mem[rd_ptr_q];
  assign head_strb_o  = strb_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({req_valid_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      write_mem[wr_ptr_q] <= req_write_i;
      addr_mem[wr_ptr_q]  <= req_addr_i;
      wdata_mem[wr_ptr_q] <= req_wdata_i;
      strb_mem[wr_ptr_q]  <= req_strb_i;
    end
  end

endmodule

//--- src/soc_map_pkg.sv
// Memory map of the system bus and the address layout seen by the targets
// The router decodes regions with it, the targets pick words and bytes with it
package soc_map_pkg;

  localparam int unsigned AddrWidth = 32;

  // Region bases and lengths in bytes
  localparam logic [AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength  = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] UartBase   = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] UartLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] DramBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength = 32'h0000_0800;

  // Address split into upper bits, 64-bit word index and byte offset
  localparam int unsigned UpperWidth      = 21;
  localparam int unsigned IndexWidth      = 8;
  localparam int unsigned OffsetWidth     = 3;
  localparam int unsigned ConsoleOffWidth = IndexWidth + OffsetWidth;
  localparam int unsigned SramWords       = 2 ** IndexWidth;

  typedef enum logic [1:0] {ROM, UART, DRAM, NONE} target_e;

  typedef union packed {
    logic [AddrWidth-1:0] flat;
    struct packed {
      logic [UpperWidth-1:0]  upper;
      logic [IndexWidth-1:0]  index;
      logic [OffsetWidth-1:0] offset;
    } fields;
  } addr_word_u;

  // Boot image, repeats every BootWords words across the ROM region
  localparam int unsigned BootWords   = 8;
  localparam int unsigned BootIdxWidth = $clog2(BootWords);
  localparam logic [bus_pkg::DataWidth-1:0] BootImage [BootWords] = '{
    64'h0000_0297_0182_8293, 64'h0002_8067_0000_0013,
    64'h1000_0537_0480_0593, 64'h00b5_0023_0000_0073,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210, 64'h5a5a_a5a5_0f0f_f0f0
  };

  // Console register offsets inside the UART region
  localparam logic [ConsoleOffWidth-1:0] ConsoleTxOff   = 11'h000;
  localparam logic [ConsoleOffWidth-1:0] ConsoleExitOff = 11'h008;
  localparam int unsigned ExitWidth = 32;

endpackage

//--- src/soc_top.sv
// Top level of the bus: request FIFO, address router and the three targets
// The requester side uses credits both ways, see the router for response timing
`timescale 1ns/10ps

module soc_top (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              req_valid_i,
  input  logic                              req_write_i,
  input  logic [soc_map_pkg::AddrWidth-1:0] req_addr_i,
  input  logic [bus_pkg::DataWidth-1:0]     req_wdata_i,
  input  logic [bus_pkg::StrbWidth-1:0]     req_strb_i,
  input  logic                              rsp_credit_i,
  output logic                              req_credit_o,
  output logic                              rsp_valid_o,
  output logic [bus_pkg::DataWidth-1:0]     rsp_rdata_o,
  output logic                              rsp_err_o,
  output logic                              tx_valid_o,
  output logic [7:0]                        tx_data_o,
  output logic [soc_map_pkg::ExitWidth-1:0] exit_o
);

  logic                                    head_valid;
  logic                                    head_write;
  logic [soc_map_pkg::AddrWidth-1:0]       head_addr;
  logic [bus_pkg::DataWidth-1:0]           head_wdata;
  logic [bus_pkg::StrbWidth-1:0]           head_strb;
  logic                                    pop;
  logic                                    rom_sel;
  logic                                    sram_sel;
  logic                                    console_sel;
  logic                                    mem_write;
  logic [soc_map_pkg::IndexWidth-1:0]      mem_index;
  logic [bus_pkg::DataWidth-1:0]           mem_wdata;
  logic [bus_pkg::StrbWidth-1:0]           mem_strb;
  logic [soc_map_pkg::ConsoleOffWidth-1:0] console_off;
  logic [bus_pkg::DataWidth-1:0]           rom_rdata;
  logic [bus_pkg::DataWidth-1:0]           sram_rdata;
  logic [bus_pkg::DataWidth-1:0]           console_rdata;

  req_buffer i_req_buffer (
    .clk_i        (clk_i       ),
    .arst_n_i     (arst_n_i    ),
    .req_valid_i  (req_valid_i ),
    .req_write_i  (req_write_i ),
    .req_addr_i   (req_addr_i  ),
    .req_wdata_i  (req_wdata_i ),
    .req_strb_i   (req_strb_i  ),
    .pop_i        (pop         ),
    .head_valid_o (head_valid  ),
    .head_write_o (head_write  ),
    .head_addr_o  (head_addr   ),
    .head_wdata_o (head_wdata  ),
    .head_strb_o  (head_strb   ),
    .req_credit_o (req_credit_o)
  );

  addr_router i_addr_router (
    .clk_i           (clk_i        ),
    .arst_n_i        (arst_n_i     ),
    .head_valid_i    (head_valid   ),
    .head_write_i    (head_write   ),
    .head_addr_i     (head_addr    ),
    .head_wdata_i    (head_wdata   ),
    .head_strb_i     (head_strb    ),
    .rsp_credit_i    (rsp_credit_i ),
    .rom_rdata_i     (rom_rdata    ),
    .sram_rdata_i    (sram_rdata   ),
    .console_rdata_i (console_rdata),
    .pop_o           (pop          ),
    .rom_sel_o       (rom_sel      ),
    .sram_sel_o      (sram_sel     ),
    .console_sel_o   (console_sel  ),
    .mem_write_o     (mem_write    ),
    .mem_index_o     (mem_index    ),
    .mem_wdata_o     (mem_wdata    ),
    .mem_strb_o      (mem_strb     ),
    .console_off_o   (console_off  ),
    .rsp_valid_o     (rsp_valid_o  ),
    .rsp_rdata_o     (rsp_rdata_o  ),
    .rsp_err_o       (rsp_err_o    )
  );

  boot_rom i_boot_rom (
    .clk_i   (clk_i    ),
    .sel_i   (rom_sel  ),
    .index_i (mem_index),
    .rdata_o (rom_rdata)
  );

  sram_bank i_sram_bank (
    .clk_i   (clk_i     ),
    .sel_i   (sram_sel  ),
    .write_i (mem_write ),
    .index_i (mem_index ),
    .wdata_i (mem_wdata ),
    .strb_i  (mem_strb  ),
    .rdata_o (sram_rdata)
  );

  // Console sits next to the memories, its outputs go straight to the top
  console_regs i_console_regs (
    .clk_i      (clk_i        ),
    .arst_n_i   (arst_n_i     ),
    .sel_i      (console_sel  ),
    .write_i    (mem_write    ),
    .off_i      (console_off  ),
    .wdata_i    (mem_wdata    ),
    .rdata_o    (console_rdata),
    .tx_valid_o (tx_valid_o   ),
    .tx_data_o  (tx_data_o    ),
    .exit_o     (exit_o       )
  );

endmodule

//--- src/sram_bank.sv
// Single-port SRAM behind the DRAM region, 64-bit words
// Byte strobes qualify writes; reads return the word one cycle after the select
`timescale 1ns/10ps

module sram_bank (
  input  logic                               clk_i,
  input  logic                               sel_i,
  input  logic                               write_i,
  input  logic [soc_map_pkg::IndexWidth-1:0] index_i,
  input  logic [bus_pkg::DataWidth-1:0]      wdata_i,
  input  logic [bus_pkg::StrbWidth-1:0]      strb_i,
  output logic [bus_pkg::DataWidth-1:0]      rdata_o
);

  logic [bus_pkg::DataWidth-1:0] mem [soc_map_pkg::SramWords];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (write_i) begin
        for (int b = 0; b < bus_pkg::StrbWidth; b++) begin
          if (strb_i[b]) begin
            mem[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[index_i];
      end
    end
  end

endmodule

//--- verification/clk_gen.sv
// Clock and reset source for the testbench
// 100 ns clock, reset held low for two rising edges and released on a falling edge
`timescale 1ns/10ps

module clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int HalfPeriod  = 50;
  localparam int ResetCycles = 2;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

//--- verification/tb_soc.sv
// Table-driven testbench for the system bus top level
// Tracks both credit pools, checks responses in order and the console outputs
`timescale 1ns/10ps

module tb_soc;

  localparam int unsigned Seed       = 32040;
  localparam int          WaitLimit  = 300;
  localparam int          ReqCredits = int'(bus_pkg::ReqCredits);
  localparam int          RspCredits = int'(bus_pkg::RspCredits);

  localparam logic [31:0] Rom     = soc_map_pkg::RomBase;
  localparam logic [31:0] Uart    = soc_map_pkg::UartBase;
  localparam logic [31:0] Dram    = soc_map_pkg::DramBase;
  localparam logic [31:0] TxReg   = Uart + 32'(soc_map_pkg::ConsoleTxOff);
  localparam logic [31:0] ExitReg = Uart + 32'(soc_map_pkg::ConsoleExitOff);

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  strb;
    logic [63:0] rdata;
    logic        err;
  } op_t;

  logic        clk_i, arst_n_i, req_valid_i, req_write_i, rsp_credit_i;
  logic [31:0] req_addr_i;
  logic [63:0] req_wdata_i;
  logic [7:0]  req_strb_i;
  logic        req_credit_o, rsp_valid_o, rsp_err_o, tx_valid_o;
  logic [63:0] rsp_rdata_o;
  logic [7:0]  tx_data_o;
  logic [31:0] exit_o;

  op_t         ops[$];
  op_t         exp_q[$];
  logic [7:0]  tx_q[$];
  logic [31:0] exp_exit;
  int          req_credits;
  int          rsp_avail;
  int          owed;
  int          delay;

  clk_gen i_clk_gen (.clk_o(clk_i), .arst_n_o(arst_n_i));

  soc_top dut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_valid_i(req_valid_i), .req_write_i(req_write_i), .req_addr_i(req_addr_i),
    .req_wdata_i(req_wdata_i), .req_strb_i(req_strb_i), .rsp_credit_i(rsp_credit_i),
    .req_credit_o(req_credit_o), .rsp_valid_o(rsp_valid_o),
    .rsp_rdata_o(rsp_rdata_o), .rsp_err_o(rsp_err_o),
    .tx_valid_o(tx_valid_o), .tx_data_o(tx_data_o), .exit_o(exit_o)
  );

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    report_error($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, want));
  endtask

  task automatic add_op(input logic w, input logic [31:0] a, input logic [63:0] d,
                        input logic [7:0] s, input logic [63:0] r, input logic e);
    op_t op;
    op.write = w;
    op.addr  = a;
    op.wdata = d;
    op.strb  = s;
    op.rdata = r;
    op.err   = e;
    ops.push_back(op);
  endtask

  // Each row holds write flag, address, write data, strobe, expected read data and error
  task automatic build_table();
    add_op(1'b0, Rom,                64'h0, 8'hFF, soc_map_pkg::BootImage[0], 1'b0);
    add_op(1'b0, Rom + 32'h18,       64'h0, 8'hFF, soc_map_pkg::BootImage[3], 1'b0);
    add_op(1'b0, Rom + 32'h48,       64'h0, 8'hFF, soc_map_pkg::BootImage[1], 1'b0);
    add_op(1'b0, Rom + 32'hFFF8,     64'h0, 8'hFF, soc_map_pkg::BootImage[7], 1'b0);
    add_op(1'b1, Rom + 32'h10,       '1,    8'hFF, 64'h0,                     1'b0);
    add_op(1'b0, Rom + 32'h10,       64'h0, 8'hFF, soc_map_pkg::BootImage[2], 1'b0);
    add_op(1'b1, Dram,          64'h1122_3344_5566_7788, 8'hFF, 64'h0, 1'b0);
    add_op(1'b1, Dram + 32'h7F8, 64'hA5A5_5A5A_0F0F_F0F0, 8'hFF, 64'h0, 1'b0);
    add_op(1'b0, Dram,          64'h0, 8'hFF, 64'h1122_3344_5566_7788, 1'b0);
    add_op(1'b0, Dram + 32'h7F8, 64'h0, 8'hFF, 64'hA5A5_5A5A_0F0F_F0F0, 1'b0);
    add_op(1'b1, Dram,          64'hFFFF_FFFF_AABB_CCDD, 8'h0F, 64'h0, 1'b0);
    add_op(1'b0, Dram,          64'h0, 8'hFF, 64'h1122_3344_AABB_CCDD, 1'b0);
    add_op(1'b1, Dram,          64'hEE00_0000_0000_00FF, 8'h81, 64'h0, 1'b0);
    add_op(1'b0, Dram,          64'h0, 8'hFF, 64'hEE22_3344_AABB_CCFF, 1'b0);
    // Unmapped space and the first address past each region
    add_op(1'b0, 32'h0,                 64'h0, 8'hFF, 64'h0, 1'b1);
    add_op(1'b0, Rom - 32'h8,           64'h0, 8'hFF, 64'h0, 1'b1);
    add_op(1'b0, Rom + 32'h0001_0000,   64'h0, 8'hFF, 64'h0, 1'b1);
    add_op(1'b0, Uart + 32'h0000_1000,  64'h0, 8'hFF, 64'h0, 1'b1);
    add_op(1'b1, Dram + 32'h800, 64'h0BAD_0BAD_0BAD_0BAD, 8'hFF, 64'h0, 1'b1);
    add_op(1'b0, Dram + 32'h800, 64'h0, 8'hFF, 64'h0, 1'b1);
    add_op(1'b0, Dram,          64'h0, 8'hFF, 64'hEE22_3344_AABB_CCFF, 1'b0);
    add_op(1'b1, TxReg,   64'h1234_5678_9ABC_DE48, 8'hFF, 64'h0, 1'b0);
    add_op(1'b1, TxReg,   64'h0000_0000_0000_FF69, 8'hFF, 64'h0, 1'b0);
    add_op(1'b1, TxReg,   64'h0000_0000_0000_0021, 8'hFF, 64'h0, 1'b0);
    add_op(1'b0, TxReg,   64'h0, 8'hFF, 64'h0, 1'b0);
    add_op(1'b1, ExitReg, 64'hFFFF_FFFF_0000_002A, 8'hFF, 64'h0, 1'b0);
    add_op(1'b0, ExitReg, 64'h0, 8'hFF, 64'h0000_0000_0000_002A, 1'b0);
    add_op(1'b1, Uart + 32'h10, 64'h77, 8'hFF, 64'h0, 1'b0);
    add_op(1'b1, ExitReg, 64'h0000_0000_DEAD_0001, 8'hFF, 64'h0, 1'b0);
    add_op(1'b0, ExitReg, 64'h0, 8'hFF, 64'h0000_0000_DEAD_0001, 1'b0);
    add_op(1'b0, Dram + 32'h7F8, 64'h0, 8'hFF, 64'hA5A5_5A5A_0F0F_F0F0, 1'b0);
  endtask

  // Every driver step lands on a falling edge and collects returned request credits
  task automatic next_cycle();
    @(negedge clk_i);
    if (req_credit_o === 1'b1) begin
      req_credits++;
    end
    assert (req_credits <= ReqCredits)
      else report_error("more request credits returned than were ever handed out");
  endtask

  task automatic check_idle();
    assert (rsp_valid_o === 1'b0) else report_mismatch("rsp_valid_o", 64'(rsp_valid_o), 64'h0);
    assert (req_credit_o === 1'b0)
      else report_mismatch("req_credit_o", 64'(req_credit_o), 64'h0);
    assert (tx_valid_o === 1'b0) else report_mismatch("tx_valid_o", 64'(tx_valid_o), 64'h0);
    assert (exit_o === 32'h0) else report_mismatch("exit_o", 64'(exit_o), 64'h0);
  endtask

  task automatic send_op(input op_t op);
    int n;
    n = 0;
    while (req_credits == 0) begin
      assert (n < WaitLimit) else report_error("timeout waiting for a request credit");
      next_cycle();
      n++;
    end
    req_valid_i = 1'b1;
    req_write_i = op.write;
    req_addr_i  = op.addr;
    req_wdata_i = op.wdata;
    req_strb_i  = op.strb;
    req_credits--;
    exp_q.push_back(op);
    // Console side effects follow from the register offsets
    if (op.write && op.addr == TxReg) begin
      tx_q.push_back(op.wdata[7:0]);
    end
    if (op.write && op.addr == ExitReg) begin
      exp_exit = op.wdata[31:0];
    end
    next_cycle();
    req_valid_i = 1'b0;
  endtask

  function automatic int draw_delay();
    int unsigned r;
    r = $urandom;
    // Now and then hold every credit back for a long stretch
    if (r[2:0] == 3'd0) begin
      return 10;
    end
    return int'(r[4:3]);
  endfunction

  task automatic check_response();
    op_t exp;
    int  usable;
    assert (exp_q.size() > 0) else report_error("response arrived with no request outstanding");
    // A credit still on the wire reached the DUT too late for the request answered now
    usable = rsp_avail - ((rsp_credit_i === 1'b1) ? 1 : 0);
    assert (usable > 0) else report_error("response sent while the DUT held no credit");
    exp = exp_q.pop_front();
    rsp_avail--;
    owed++;
    assert (rsp_rdata_o === exp.rdata)
      else report_mismatch("rsp_rdata_o", rsp_rdata_o, exp.rdata);
    assert (rsp_err_o === exp.err)
      else report_mismatch("rsp_err_o", 64'(rsp_err_o), 64'(exp.err));
  endtask

  task automatic check_tx();
    logic [7:0] exp_byte;
    assert (tx_q.size() > 0) else report_error("console byte sent with no console write pending");
    exp_byte = tx_q.pop_front();
    assert (tx_data_o === exp_byte)
      else report_mismatch("tx_data_o", 64'(tx_data_o), 64'(exp_byte));
  endtask

  task automatic return_credit();
    rsp_credit_i = 1'b0;
    if (owed > 0) begin
      if (delay == 0) begin
        rsp_credit_i = 1'b1;
        owed--;
        rsp_avail++;
        delay = draw_delay();
      end else begin
        delay--;
      end
    end
  endtask

  initial begin : watch_responses
    void'($urandom(Seed));
    rsp_credit_i = 1'b0;
    rsp_avail    = RspCredits;
    owed         = 0;
    delay        = 0;
    forever begin
      @(negedge clk_i);
      if (arst_n_i === 1'b1) begin
        if (rsp_valid_o === 1'b1) begin
          check_response();
        end
        if (tx_valid_o === 1'b1) begin
          check_tx();
        end
        return_credit();
      end
    end
  end

  initial begin : drive_table
    int n;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_strb_i  = '0;
    exp_exit    = '0;
    req_credits = ReqCredits;
    build_table();
    n = 0;
    while (arst_n_i !== 1'b1) begin
      assert (n < WaitLimit) else report_error("timeout waiting for reset release");
      next_cycle();
      n++;
    end
    next_cycle();
    check_idle();
    foreach (ops[i]) begin
      send_op(ops[i]);
    end
    n = 0;
    while (exp_q.size() != 0 || tx_q.size() != 0) begin
      assert (n < WaitLimit) else report_error("timeout waiting for outstanding responses");
      next_cycle();
      n++;
    end
    assert (exit_o === exp_exit) else report_mismatch("exit_o", 64'(exit_o), 64'(exp_exit));
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
